/* arbiter/burstSequencer.sv */
// Burst bus FSM of the memory arbiter, issues one request and counts the acknowledge beats
`default_nettype none
`include "memArb_cfg.svh"

module burstSequencer (
	input  wire                            gpuClk,
	input  wire                            resetX,
	input  wire                            start_i,
	input  wire  memBusPkg::burstKindT     startKind_i,
	input  wire  [`MEM_ADR_W-1:0]          startAdr_i,
	input  wire                            isBlending_i,
	input  wire  [`CLUT_ADR_W-1:0]         loadAdr_i,
	input  wire                            memAck_i,
	output logic                           seqIdle_o,
	output logic                           grant_o,
	output logic                           beat_o,
	output logic [$clog2(`LINE_BEATS)-1:0] beatIdx_o,
	output logic                           lastBeat_o,
	output logic                           memReq_o,
	output logic [`MEM_ADR_W-1:0]          memAdr_o,
	output logic [$clog2(`LINE_BEATS)-1:0] memCnt_o,
	output logic                           memWrt_o,
	output logic                           saveLoadOnGoing_o
);
	import memBusPkg::*;

	localparam int CntW = $clog2(`LINE_BEATS);

	seqStateT        stateQ;
	burstKindT       kindQ;
	logic [CntW-1:0] beatCntQ;
	logic            tailQ;
	logic            isBgBurst;
	logic            chainRd;

	// Beat count minus one for a burst kind
	function automatic logic [CntW-1:0] lastIdx(input burstKindT kind);
		if (kind == BK_TEX_RD) begin
			return CntW'(`TEX_BEATS - 1);
		end
		return CntW'(`LINE_BEATS - 1);
	endfunction

	assign seqIdle_o  = (stateQ == SEQ_IDLE);
	assign grant_o    = seqIdle_o & start_i;
	assign memReq_o   = (stateQ == SEQ_REQ);
	assign memWrt_o   = (kindQ == BK_BG_WR);
	// Acks only count once the request went out
	assign beat_o     = memAck_i & ((stateQ == SEQ_WAIT) | (stateQ == SEQ_BEATS));
	assign beatIdx_o  = beatCntQ;
	assign lastBeat_o = beat_o & (beatCntQ == memCnt_o);
	assign isBgBurst  = (kindQ == BK_BG_WR) | (kindQ == BK_BG_RD);
	// Save then load when blending
	assign chainRd    = lastBeat_o & (kindQ == BK_BG_WR) & isBlending_i;
	// Tail covers the cycle after the last BG beat
	assign saveLoadOnGoing_o = (isBgBurst & !seqIdle_o) | tailQ;

	// ----------------------------------------------------------------------
	// FSM and beat counter
	// ----------------------------------------------------------------------
	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			stateQ   <= SEQ_IDLE;
			kindQ    <= BK_TEX_RD;
			beatCntQ <= '0;
			tailQ    <= 1'b0;
		end else begin
			tailQ <= lastBeat_o & isBgBurst & !chainRd;
			if (beat_o) begin
				beatCntQ <= lastBeat_o ? '0 : beatCntQ + 1'b1;
			end
			case (stateQ)
				SEQ_IDLE: begin
					if (start_i) begin
						kindQ  <= startKind_i;
						stateQ <= SEQ_REQ;
					end
				end
				SEQ_REQ: stateQ <= SEQ_WAIT;
				SEQ_WAIT, SEQ_BEATS: begin
					if (chainRd) begin
						kindQ  <= BK_BG_RD;
						stateQ <= SEQ_REQ;
					end else if (lastBeat_o) begin
						stateQ <= SEQ_IDLE;
					end else if (beat_o) begin
						stateQ <= SEQ_BEATS;
					end
				end
				default: stateQ <= SEQ_IDLE;
			endcase
		end
	end

	// Request payload, loaded at grant or at the chained load
	always_ff @(posedge gpuClk) begin
		if (grant_o) begin
			memAdr_o <= startAdr_i;
			memCnt_o <= lastIdx(startKind_i);
		end else if (chainRd) begin
			memAdr_o <= {loadAdr_i, {`LINE_ADR_SHIFT{1'b0}}};
			memCnt_o <= lastIdx(BK_BG_RD);
		end
	end

	// Memory answers only after the request pulse, never while idle
	aReqAck: assert property (@(posedge gpuClk) disable iff (resetX)
		!(memReq_o && memAck_i));
	aIdleAck: assert property (@(posedge gpuClk) disable iff (resetX)
		seqIdle_o |-> !memAck_i);

endmodule

`default_nettype wire

/* arbiter/clientSelect.sv */
// Fixed priority client choice for the memory arbiter, feeds start requests to the sequencer
`default_nettype none
`include "memArb_cfg.svh"

module clientSelect (
	input  wire                     gpuClk,
	input  wire                     resetX,
	input  wire                     requTexL_i,
	input  wire                     requTexR_i,
	input  wire  [`TEX_ADR_W-1:0]   adrTexL_i,
	input  wire  [`TEX_ADR_W-1:0]   adrTexR_i,
	input  wire                     requClutL_i,
	input  wire                     requClutR_i,
	input  wire  [`CLUT_ADR_W-1:0]  adrClutL_i,
	input  wire  [`CLUT_ADR_W-1:0]  adrClutR_i,
	input  wire                     isBlending_i,
	input  wire  gpuClientPkg::bgCmdT bgCmd_i,
	input  wire  [`CLUT_ADR_W-1:0]  saveAdr_i,
	input  wire  [`CLUT_ADR_W-1:0]  loadAdr_i,
	input  wire                     seqIdle_i,
	output logic                    start_o,
	output memBusPkg::burstKindT    startKind_o,
	output gpuClientPkg::clientSideT startSide_o,
	output logic [`MEM_ADR_W-1:0]   startAdr_o
);
	import memBusPkg::*;
	import gpuClientPkg::*;

	logic bgPrevQ;
	logic bgActive;
	logic bgEdge;
	logic bgWrite;
	logic bgRead;

	// ----------------------------------------------------------------------
	// Background command edge
	// ----------------------------------------------------------------------
	assign bgActive = (bgCmd_i != BG_NONE);
	assign bgEdge   = bgActive & !bgPrevQ;
	// Further block saves first, blending read is chained later
	assign bgWrite  = bgEdge & (bgCmd_i == BG_FURTHER);
	// First block only loads, and only when blending
	assign bgRead   = bgEdge & (bgCmd_i == BG_FIRST) & isBlending_i;

	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			bgPrevQ <= 1'b0;
		end else begin
			bgPrevQ <= bgActive;
		end
	end

	// ----------------------------------------------------------------------
	// Priority: BG, CLUT L, CLUT R, TEX L, TEX R
	// ----------------------------------------------------------------------
	always_comb begin
		start_o     = 1'b1;
		startKind_o = BK_TEX_RD;
		startSide_o = SIDE_LEFT;
		startAdr_o  = '0;
		if (bgWrite) begin
			startKind_o = BK_BG_WR;
			startAdr_o  = {saveAdr_i, {`LINE_ADR_SHIFT{1'b0}}};
		end else if (bgRead) begin
			startKind_o = BK_BG_RD;
			startAdr_o  = {loadAdr_i, {`LINE_ADR_SHIFT{1'b0}}};
		end else if (requClutL_i) begin
			startKind_o = BK_CLUT_RD;
			startAdr_o  = {adrClutL_i, {`LINE_ADR_SHIFT{1'b0}}};
		end else if (requClutR_i) begin
			startKind_o = BK_CLUT_RD;
			startSide_o = SIDE_RIGHT;
			startAdr_o  = {adrClutR_i, {`LINE_ADR_SHIFT{1'b0}}};
		end else if (requTexL_i) begin
			startAdr_o  = {adrTexL_i, {`TEX_ADR_SHIFT{1'b0}}};
		end else if (requTexR_i) begin
			startSide_o = SIDE_RIGHT;
			startAdr_o  = {adrTexR_i, {`TEX_ADR_SHIFT{1'b0}}};
		end else begin
			start_o = 1'b0;
		end
		// A busy bus takes nothing new
		start_o = start_o & seqIdle_i;
	end

	// Sequencer leaves idle right after every start it is given
	aStartTaken: assert property (@(posedge gpuClk) disable iff (resetX)
		start_o |-> seqIdle_i ##1 !seqIdle_i);

endmodule

`default_nettype wire

/* arbiter/refillDataPath.sv */
// Refill datapath of the memory arbiter, turns bus beats into cache writes and BG blocks
`default_nettype none
`include "memArb_cfg.svh"

module refillDataPath (
	input  wire                              gpuClk,
	input  wire                              resetX,
	input  wire                              grant_i,
	input  wire  memBusPkg::burstKindT       grantKind_i,
	input  wire  gpuClientPkg::clientSideT   grantSide_i,
	input  wire  [`TEX_ADR_W-1:0]            grantAdr_i,
	input  wire                              beat_i,
	input  wire  [$clog2(`LINE_BEATS)-1:0]   beatIdx_i,
	input  wire                              lastBeat_i,
	input  wire  [`MEM_DATA_W-1:0]           memDat_i,
	input  wire  [`BG_BLOCK_W-1:0]           exportedBgBlock_i,
	input  wire  [`BG_MASK_W-1:0]            exportedBgMask_i,
	output logic                             texDoneL_o,
	output logic                             texDoneR_o,
	output logic                             texWrite_o,
	output logic [`TEX_ADR_W-1:0]            texAdr_o,
	output logic [`TEX_BEATS*`MEM_DATA_W-1:0] texData_o,
	output logic                             clutDoneL_o,
	output logic                             clutDoneR_o,
	output logic                             clutWrite_o,
	output logic [$clog2(`LINE_BEATS)-1:0]   clutIndex_o,
	output logic [`MEM_DATA_W-1:0]           clutData_o,
	output logic                             importBGBlockSingleClock_o,
	output logic [`BG_BLOCK_W-1:0]           importedBGBlock_o,
	output logic [`MEM_DATA_W-1:0]           memDat_o,
	output logic [`MEM_DATA_W/8-1:0]         memSel_o
);
	import memBusPkg::*;
	import gpuClientPkg::*;

	burstKindT             kindQ;
	clientSideT            sideQ;
	logic [`TEX_ADR_W-1:0] lineAdrQ;
	logic [`MEM_DATA_W-1:0] texLoQ;
	logic                  importQ;
	logic                  texBeat;
	logic                  clutBeat;
	logic                  bgRdBeat;
	logic [1:0]            halfMask;

	assign texBeat  = beat_i & (kindQ == BK_TEX_RD);
	assign clutBeat = beat_i & (kindQ == BK_CLUT_RD);
	assign bgRdBeat = beat_i & (kindQ == BK_BG_RD);

	// ----------------------------------------------------------------------
	// Cache writes, same cycle as the beat
	// ----------------------------------------------------------------------
	// Second beat is the upper word
	assign texWrite_o  = texBeat & lastBeat_i;
	assign texAdr_o    = lineAdrQ;
	assign texData_o   = {memDat_i, texLoQ};
	// Done goes to the side that was granted
	assign texDoneL_o  = texWrite_o & (sideQ == SIDE_LEFT);
	assign texDoneR_o  = texWrite_o & (sideQ == SIDE_RIGHT);
	assign clutWrite_o = clutBeat;
	assign clutIndex_o = beatIdx_i;
	assign clutData_o  = memDat_i;
	assign clutDoneL_o = clutBeat & lastBeat_i & (sideQ == SIDE_LEFT);
	assign clutDoneR_o = clutBeat & lastBeat_i & (sideQ == SIDE_RIGHT);
	assign importBGBlockSingleClock_o = importQ;

	// Write beat from the exported block, one mask bit per halfword
	assign memDat_o = exportedBgBlock_i[beatIdx_i*`MEM_DATA_W +: `MEM_DATA_W];
	assign halfMask = exportedBgMask_i[beatIdx_i*2 +: 2];
	assign memSel_o = {halfMask[1], halfMask[1], halfMask[0], halfMask[0]};

	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			kindQ   <= BK_TEX_RD;
			sideQ   <= SIDE_LEFT;
			importQ <= 1'b0;
		end else begin
			importQ <= bgRdBeat & lastBeat_i;
			if (grant_i) begin
				kindQ <= grantKind_i;
				sideQ <= grantSide_i;
			end else if (beat_i & lastBeat_i & (kindQ == BK_BG_WR)) begin
				// Load may follow, next grant overwrites it otherwise
				kindQ <= BK_BG_RD;
			end
		end
	end

	// Line address, first texture word, BG block beats
	always_ff @(posedge gpuClk) begin
		if (grant_i) begin
			lineAdrQ <= grantAdr_i;
		end
		if (texBeat & !lastBeat_i) begin
			texLoQ <= memDat_i;
		end
		if (bgRdBeat) begin
			importedBGBlock_o[beatIdx_i*`MEM_DATA_W +: `MEM_DATA_W] <= memDat_i;
		end
	end

	// One cache port at a time, texture write right after its first beat
	aOneWrite: assert property (@(posedge gpuClk) disable iff (resetX)
		texWrite_o |-> !clutWrite_o && $past(texBeat));

endmodule

`default_nettype wire

/* common/gpuClientPkg.sv */
// Client side types of the memory arbiter, imported wherever requesters are seen
`default_nettype none

package gpuClientPkg;

	// Requester side of a cache refill
	typedef enum logic {
		SIDE_LEFT  = 1'b0,
		SIDE_RIGHT = 1'b1
	} clientSideT;

	// Background block command, acted on when it leaves BG_NONE
	typedef enum logic [1:0] {
		BG_NONE    = 2'b00,
		BG_FIRST   = 2'b01,
		BG_FURTHER = 2'b10
	} bgCmdT;

endpackage

`default_nettype wire

/* common/memArb_cfg.svh */
// Bus widths, burst lengths and address shifts of the memory arbiter, included by its RTL
`ifndef MEMARB_CFG_SVH
`define MEMARB_CFG_SVH

// ----------------------------------------------------------------------
// Video memory bus
// ----------------------------------------------------------------------
// Byte address, 1 MB of video memory
`define MEM_ADR_W 20
// One beat on the burst bus
`define MEM_DATA_W 32

// ----------------------------------------------------------------------
// Client lines
// ----------------------------------------------------------------------
// Texture line in 8 byte units
`define TEX_ADR_W 17
`define TEX_ADR_SHIFT 3
`define TEX_BEATS 2
// CLUT line and background block in 32 byte units
`define CLUT_ADR_W 15
`define LINE_ADR_SHIFT 5
`define LINE_BEATS 8
// Background block, 16 halfword pixels, one mask bit each
`define BG_BLOCK_W 256
`define BG_MASK_W 16

`endif

/* common/memBusPkg.sv */
// Bus side types of the memory arbiter, imported by the sequencer and the datapath
`default_nettype none

package memBusPkg;

	// ----------------------------------------------------------------------
	// Burst kinds
	// ----------------------------------------------------------------------
	// Same codes as the old read mode field, background write added
	typedef enum logic [2:0] {
		BK_BG_RD   = 3'd1,
		BK_CLUT_RD = 3'd2,
		BK_TEX_RD  = 3'd3,
		BK_BG_WR   = 3'd4
	} burstKindT;

	// Bus sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE  = 2'd0,
		SEQ_REQ   = 2'd1,
		SEQ_WAIT  = 2'd2,
		SEQ_BEATS = 2'd3
	} seqStateT;

endpackage

`default_nettype wire

/* rtl/memArbiter.sv */
// Memory arbiter top level, shares the video memory burst bus among the GPU clients
`default_nettype none
`include "memArb_cfg.svh"

module memArbiter (
	input  wire                              gpuClk,
	input  wire                              resetX,
	// Texture cache refill
	input  wire                              requTexL_i,
	input  wire                              requTexR_i,
	input  wire  [`TEX_ADR_W-1:0]            adrTexL_i,
	input  wire  [`TEX_ADR_W-1:0]            adrTexR_i,
	output logic                             texDoneL_o,
	output logic                             texDoneR_o,
	output logic                             texWrite_o,
	output logic [`TEX_ADR_W-1:0]            texAdr_o,
	output logic [`TEX_BEATS*`MEM_DATA_W-1:0] texData_o,
	// CLUT cache refill
	input  wire                              requClutL_i,
	input  wire                              requClutR_i,
	input  wire  [`CLUT_ADR_W-1:0]           adrClutL_i,
	input  wire  [`CLUT_ADR_W-1:0]           adrClutR_i,
	output logic                             clutDoneL_o,
	output logic                             clutDoneR_o,
	output logic                             clutWrite_o,
	output logic [$clog2(`LINE_BEATS)-1:0]   clutIndex_o,
	output logic [`MEM_DATA_W-1:0]           clutData_o,
	// Background block save and load
	input  wire                              isBlending_i,
	input  wire  gpuClientPkg::bgCmdT        bgCmd_i,
	input  wire  [`CLUT_ADR_W-1:0]           saveAdr_i,
	input  wire  [`CLUT_ADR_W-1:0]           loadAdr_i,
	input  wire  [`BG_BLOCK_W-1:0]           exportedBgBlock_i,
	input  wire  [`BG_MASK_W-1:0]            exportedBgMask_i,
	output logic                             importBGBlockSingleClock_o,
	output logic [`BG_BLOCK_W-1:0]           importedBGBlock_o,
	output logic                             saveLoadOnGoing_o,
	// Video memory burst bus
	output logic [`MEM_ADR_W-1:0]            memAdr_o,
	output logic [$clog2(`LINE_BEATS)-1:0]   memCnt_o,
	output logic [`MEM_DATA_W/8-1:0]         memSel_o,
	output logic [`MEM_DATA_W-1:0]           memDat_o,
	input  wire  [`MEM_DATA_W-1:0]           memDat_i,
	output logic                             memWrt_o,
	output logic                             memReq_o,
	input  wire                              memAck_i
);
	import memBusPkg::*;
	import gpuClientPkg::*;

	// Selector to sequencer
	logic                           seqIdle;
	logic                           start;
	burstKindT                      startKind;
	clientSideT                     startSide;
	logic [`MEM_ADR_W-1:0]          startAdr;
	// Sequencer to datapath
	logic                           grant;
	logic                           beat;
	logic [$clog2(`LINE_BEATS)-1:0] beatIdx;
	logic                           lastBeat;

	clientSelect uClientSelect (
		.gpuClk(gpuClk), .resetX(resetX),
		.requTexL_i(requTexL_i), .requTexR_i(requTexR_i),
		.adrTexL_i(adrTexL_i), .adrTexR_i(adrTexR_i),
		.requClutL_i(requClutL_i), .requClutR_i(requClutR_i),
		.adrClutL_i(adrClutL_i), .adrClutR_i(adrClutR_i),
		.isBlending_i(isBlending_i), .bgCmd_i(bgCmd_i),
		.saveAdr_i(saveAdr_i), .loadAdr_i(loadAdr_i), .seqIdle_i(seqIdle),
		.start_o(start), .startKind_o(startKind), .startSide_o(startSide),
		.startAdr_o(startAdr)
	);

	burstSequencer uBurstSequencer (
		.gpuClk(gpuClk), .resetX(resetX),
		.start_i(start), .startKind_i(startKind), .startAdr_i(startAdr),
		.isBlending_i(isBlending_i), .loadAdr_i(loadAdr_i), .memAck_i(memAck_i),
		.seqIdle_o(seqIdle), .grant_o(grant), .beat_o(beat), .beatIdx_o(beatIdx),
		.lastBeat_o(lastBeat), .memReq_o(memReq_o), .memAdr_o(memAdr_o),
		.memCnt_o(memCnt_o), .memWrt_o(memWrt_o), .saveLoadOnGoing_o(saveLoadOnGoing_o)
	);

	// Datapath keeps only the texture line part of the start address
	refillDataPath uRefillDataPath (
		.gpuClk(gpuClk), .resetX(resetX),
		.grant_i(grant), .grantKind_i(startKind), .grantSide_i(startSide),
		.grantAdr_i(startAdr[`MEM_ADR_W-1:`TEX_ADR_SHIFT]),
		.beat_i(beat), .beatIdx_i(beatIdx), .lastBeat_i(lastBeat), .memDat_i(memDat_i),
		.exportedBgBlock_i(exportedBgBlock_i), .exportedBgMask_i(exportedBgMask_i),
		.texDoneL_o(texDoneL_o), .texDoneR_o(texDoneR_o), .texWrite_o(texWrite_o),
		.texAdr_o(texAdr_o), .texData_o(texData_o),
		.clutDoneL_o(clutDoneL_o), .clutDoneR_o(clutDoneR_o), .clutWrite_o(clutWrite_o),
		.clutIndex_o(clutIndex_o), .clutData_o(clutData_o),
		.importBGBlockSingleClock_o(importBGBlockSingleClock_o),
		.importedBGBlock_o(importedBGBlock_o), .memDat_o(memDat_o), .memSel_o(memSel_o)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the memory arbiter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tbMemArbiter \
	-Mdir obj_dir -o simMemArbiter
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simMemArbiter > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "Simulation run returned status $runStatus"
	exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* sim.f */
+incdir+common
common/memBusPkg.sv
common/gpuClientPkg.sv
arbiter/clientSelect.sv
arbiter/burstSequencer.sv
arbiter/refillDataPath.sv
rtl/memArbiter.sv
test/bus_model.sv
test/tbMemArbiter.sv

/* test/bus_model.sv */
// Video memory model on the arbiter burst bus, instantiated by the testbench next to the DUT
`default_nettype none
`include "memArb_cfg.svh"

module busModel (
	input  wire                            gpuClk,
	input  wire                            resetX,
	input  wire                            memReq_i,
	input  wire  [`MEM_ADR_W-1:0]          memAdr_i,
	input  wire  [$clog2(`LINE_BEATS)-1:0] memCnt_i,
	input  wire                            memWrt_i,
	input  wire  [`MEM_DATA_W/8-1:0]       memSel_i,
	input  wire  [`MEM_DATA_W-1:0]         memDat_i,
	output logic [`MEM_DATA_W-1:0]         memDat_o,
	output logic                           memAck_o
);
	localparam int WordAdrW = `MEM_ADR_W - 2;
	localparam int CntW = $clog2(`LINE_BEATS);

	// Whole 1 MB address space as 32 bit words
	logic [`MEM_DATA_W-1:0] mem [0:(1<<WordAdrW)-1];
	logic [WordAdrW-1:0]    baseQ;
	logic [CntW-1:0]        lastQ;
	logic [CntW-1:0]        beatQ;
	logic                   wrtQ;
	logic                   busyQ;
	logic [1:0]             waitQ;
	logic [WordAdrW-1:0]    beatAdr;
	integer                 seed;

	initial begin
		seed = 32'hb438eb48;
		// Every word differs, upper half marks untouched contents
		for (int i = 0; i < (1 << WordAdrW); i++) begin
			mem[i] = i ^ 32'h5A5A0000;
		end
	end

	assign beatAdr  = baseQ + WordAdrW'(beatQ);
	// Read data valid while the ack is high
	assign memDat_o = mem[beatAdr];

	// ----------------------------------------------------------------------
	// Request, random wait of 1 to 4 cycles, then the ack run
	// ----------------------------------------------------------------------
	always @(posedge gpuClk) begin
		if (resetX) begin
			memAck_o <= 1'b0;
			busyQ    <= 1'b0;
			beatQ    <= '0;
		end else begin
			if (memAck_o) begin
				// Write beat k is on the bus during the k-th ack
				if (wrtQ) begin
					for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
						if (memSel_i[b]) begin
							mem[beatAdr][b*8 +: 8] <= memDat_i[b*8 +: 8];
						end
					end
				end
				beatQ <= beatQ + 1'b1;
				if (beatQ == lastQ) begin
					memAck_o <= 1'b0;
					busyQ    <= 1'b0;
				end
			end else if (busyQ) begin
				if (waitQ == 2'd0) begin
					memAck_o <= 1'b1;
				end else begin
					waitQ <= waitQ - 2'd1;
				end
			end
			if (memReq_i) begin
				busyQ <= 1'b1;
				baseQ <= memAdr_i[`MEM_ADR_W-1:2];
				lastQ <= memCnt_i;
				wrtQ  <= memWrt_i;
				beatQ <= '0;
				waitQ <= 2'($random(seed));
			end
		end
	end

endmodule

`default_nettype wire

/* test/tbMemArbiter.sv */
// Directed testbench of the memory arbiter, top of the simulation with the memory model on the bus
`default_nettype none
`include "memArb_cfg.svh"

module tbMemArbiter;
	import gpuClientPkg::*;

	localparam int CntW = $clog2(`LINE_BEATS);
	localparam int WordW = `MEM_ADR_W - 2;
	// Ten bursts of at most 8 beats and 4 wait cycles, plus idle gaps, fit many times over
	localparam int TimeoutCycles = 3000;
	// Done pulse codes in the log
	localparam int DoneClutL = 1;
	localparam int DoneClutR = 2;
	localparam int DoneTexL = 3;
	localparam int DoneTexR = 4;

	logic                          gpuClk;
	logic                          resetX;
	logic                          requTexL;
	logic                          requTexR;
	logic [`TEX_ADR_W-1:0]         adrTexL;
	logic [`TEX_ADR_W-1:0]         adrTexR;
	logic                          requClutL;
	logic                          requClutR;
	logic [`CLUT_ADR_W-1:0]        adrClutL;
	logic [`CLUT_ADR_W-1:0]        adrClutR;
	logic                          isBlending;
	bgCmdT                         bgCmd;
	logic [`CLUT_ADR_W-1:0]        saveAdr;
	logic [`CLUT_ADR_W-1:0]        loadAdr;
	logic [`BG_BLOCK_W-1:0]        exportedBgBlock;
	logic [`BG_MASK_W-1:0]         exportedBgMask;
	logic                          texDoneL;
	logic                          texDoneR;
	logic                          texWrite;
	logic [`TEX_ADR_W-1:0]         texAdr;
	logic [`TEX_BEATS*`MEM_DATA_W-1:0] texData;
	logic                          clutDoneL;
	logic                          clutDoneR;
	logic                          clutWrite;
	logic [CntW-1:0]               clutIndex;
	logic [`MEM_DATA_W-1:0]        clutData;
	logic                          importPulse;
	logic [`BG_BLOCK_W-1:0]        importedBlock;
	logic                          saveLoadOnGoing;
	logic [`MEM_ADR_W-1:0]         memAdr;
	logic [CntW-1:0]               memCnt;
	logic [`MEM_DATA_W/8-1:0]      memSel;
	logic [`MEM_DATA_W-1:0]        memDatWr;
	logic [`MEM_DATA_W-1:0]        memDatRd;
	logic                          memWrt;
	logic                          memReq;
	logic                          memAck;

	int     cycleCnt = 0;
	int     errCnt = 0;
	int     testCnt = 0;
	int     failCnt = 0;
	int     wrReqCnt = 0;
	int     rdReqCnt = 0;
	int     doneLog[$];
	integer seed;

	memArbiter UUT (
		.gpuClk(gpuClk), .resetX(resetX),
		.requTexL_i(requTexL), .requTexR_i(requTexR), .adrTexL_i(adrTexL), .adrTexR_i(adrTexR),
		.texDoneL_o(texDoneL), .texDoneR_o(texDoneR), .texWrite_o(texWrite),
		.texAdr_o(texAdr), .texData_o(texData),
		.requClutL_i(requClutL), .requClutR_i(requClutR),
		.adrClutL_i(adrClutL), .adrClutR_i(adrClutR),
		.clutDoneL_o(clutDoneL), .clutDoneR_o(clutDoneR), .clutWrite_o(clutWrite),
		.clutIndex_o(clutIndex), .clutData_o(clutData),
		.isBlending_i(isBlending), .bgCmd_i(bgCmd), .saveAdr_i(saveAdr), .loadAdr_i(loadAdr),
		.exportedBgBlock_i(exportedBgBlock), .exportedBgMask_i(exportedBgMask),
		.importBGBlockSingleClock_o(importPulse), .importedBGBlock_o(importedBlock),
		.saveLoadOnGoing_o(saveLoadOnGoing),
		.memAdr_o(memAdr), .memCnt_o(memCnt), .memSel_o(memSel), .memDat_o(memDatWr),
		.memDat_i(memDatRd), .memWrt_o(memWrt), .memReq_o(memReq), .memAck_i(memAck)
	);

	busModel busMem (
		.gpuClk(gpuClk), .resetX(resetX), .memReq_i(memReq), .memAdr_i(memAdr),
		.memCnt_i(memCnt), .memWrt_i(memWrt), .memSel_i(memSel), .memDat_i(memDatWr),
		.memDat_o(memDatRd), .memAck_o(memAck)
	);

	initial begin
		gpuClk = 1'b0;
		forever #4 gpuClk = ~gpuClk;
	end

	// ----------------------------------------------------------------------
	// Monitors and timeout
	// ----------------------------------------------------------------------
	// Sampled mid cycle, outputs are settled there
	always @(negedge gpuClk) begin
		if (!resetX) begin
			if (clutDoneL) begin
				doneLog.push_back(DoneClutL);
			end
			if (clutDoneR) begin
				doneLog.push_back(DoneClutR);
			end
			if (texDoneL) begin
				doneLog.push_back(DoneTexL);
			end
			if (texDoneR) begin
				doneLog.push_back(DoneTexR);
			end
			if (memReq && memWrt) begin
				wrReqCnt++;
			end
			if (memReq && !memWrt) begin
				rdReqCnt++;
			end
		end
	end

	always @(posedge gpuClk) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= TimeoutCycles) begin
			$display("Timeout after %0d cycles, the DUT never answered a test", cycleCnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Initial memory contents, word address XOR fixed tag
	function automatic logic [31:0] initWord(input logic [WordW-1:0] wordAdr);
		return 32'(wordAdr) ^ 32'h5A5A0000;
	endfunction

	// One select bit per halfword
	function automatic logic [31:0] mergeHalves(input logic [31:0] oldW, input logic [31:0] newW,
		input logic [1:0] halfSel);
		logic [31:0] res;
		res = oldW;
		if (halfSel[0]) begin
			res[15:0] = newW[15:0];
		end
		if (halfSel[1]) begin
			res[31:16] = newW[31:16];
		end
		return res;
	endfunction

	task automatic expectTrue(input logic ok, input string msg);
		assert (ok) else begin
			$display("ERROR at %0t: %s", $time, msg);
			errCnt++;
		end
	endtask

	task automatic finishTest(input string name, input int errBefore);
		testCnt++;
		if (errCnt == errBefore) begin
			$display("Test %0s finished without errors", name);
		end else begin
			failCnt++;
			$display("Test %0s finished with %0d errors", name, errCnt - errBefore);
		end
	endtask

	// Imported block against the untouched model block
	task automatic checkLoadedBlock(input logic [`CLUT_ADR_W-1:0] line);
		logic [31:0] expW;
		for (int k = 0; k < `LINE_BEATS; k++) begin
			expW = initWord({line, CntW'(k)});
			expectTrue(importedBlock[k*32 +: 32] === expW, $sformatf(
				"importedBGBlock_o word %0d is %h, expected %h", k, importedBlock[k*32 +: 32], expW));
		end
	endtask

	task automatic waitImport();
		do begin
			@(negedge gpuClk);
		end while (!importPulse);
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------
	task automatic texLeftRefill();
		int                    errBefore;
		logic [`TEX_ADR_W-1:0] line;
		logic [63:0]           expData;
		errBefore = errCnt;
		line = 17'h01234;
		// Higher word address goes to the upper half
		expData = {initWord({line, 1'b1}), initWord({line, 1'b0})};
		doneLog.delete();
		@(posedge gpuClk);
		requTexL <= 1'b1;
		adrTexL <= line;
		do begin
			@(negedge gpuClk);
		end while (!texWrite);
		expectTrue(texData === expData, $sformatf("texData_o %h, expected %h", texData, expData));
		expectTrue(texAdr === line, $sformatf("texAdr_o %h, expected %h", texAdr, line));
		@(posedge gpuClk);
		requTexL <= 1'b0;
		repeat (2) @(posedge gpuClk);
		expectTrue(doneLog.size() == 1 && doneLog[0] == DoneTexL,
			"texture left refill gave other done pulses than one texDoneL_o");
		finishTest("texture left refill", errBefore);
	endtask

	task automatic clutRightRefill();
		int                     errBefore;
		int                     n;
		logic [`CLUT_ADR_W-1:0] line;
		logic [31:0]            expW;
		errBefore = errCnt;
		line = 15'h0456;
		n = 0;
		doneLog.delete();
		@(posedge gpuClk);
		requClutR <= 1'b1;
		adrClutR <= line;
		while (n < `LINE_BEATS) begin
			@(negedge gpuClk);
			if (clutWrite) begin
				expW = initWord({line, CntW'(n)});
				expectTrue(clutIndex === CntW'(n),
					$sformatf("clutIndex_o %0d, expected %0d", clutIndex, n));
				expectTrue(clutData === expW, $sformatf("clutData_o %h, expected %h", clutData, expW));
				// Done only with the eighth write
				expectTrue(clutDoneR === (n == `LINE_BEATS - 1),
					$sformatf("clutDoneR_o is %b at write %0d", clutDoneR, n));
				n++;
			end
		end
		@(posedge gpuClk);
		requClutR <= 1'b0;
		repeat (2) @(posedge gpuClk);
		expectTrue(doneLog.size() == 1 && doneLog[0] == DoneClutR,
			"CLUT right refill gave other done pulses than one clutDoneR_o");
		finishTest("CLUT right refill", errBefore);
	endtask

	task automatic priorityOrder();
		int         errBefore;
		int         pending;
		logic [3:0] seen;
		errBefore = errCnt;
		doneLog.delete();
		@(posedge gpuClk);
		requClutL <= 1'b1;
		adrClutL <= 15'h0010;
		requClutR <= 1'b1;
		adrClutR <= 15'h0020;
		requTexL <= 1'b1;
		adrTexL <= 17'h00300;
		requTexR <= 1'b1;
		adrTexR <= 17'h00500;
		pending = 4;
		// Each requester lets go after its own done pulse
		while (pending > 0) begin
			@(negedge gpuClk);
			seen = {clutDoneL, clutDoneR, texDoneL, texDoneR};
			@(posedge gpuClk);
			if (seen[3]) begin
				requClutL <= 1'b0;
			end
			if (seen[2]) begin
				requClutR <= 1'b0;
			end
			if (seen[1]) begin
				requTexL <= 1'b0;
			end
			if (seen[0]) begin
				requTexR <= 1'b0;
			end
			pending = pending - $countones(seen);
		end
		repeat (2) @(posedge gpuClk);
		expectTrue(doneLog.size() == 4, $sformatf("%0d done pulses, expected 4", doneLog.size()));
		for (int i = 0; i < 4; i++) begin
			expectTrue(doneLog[i] == i + 1, $sformatf("done pulse %0d came from client %0d, expected %0d",
				i, doneLog[i], i + 1));
		end
		finishTest("fixed priority", errBefore);
	endtask

	task automatic furtherBlockBlend();
		int                     errBefore;
		int                     wrBefore;
		int                     rdBefore;
		logic [`BG_BLOCK_W-1:0] block;
		logic [`BG_MASK_W-1:0]  mask;
		logic [`CLUT_ADR_W-1:0] saveLine;
		logic [`CLUT_ADR_W-1:0] loadLine;
		logic [WordW-1:0]       wAdr;
		logic [31:0]            expW;
		errBefore = errCnt;
		saveLine = 15'h0100;
		loadLine = 15'h0200;
		mask = 16'hB4C3;
		for (int k = 0; k < `LINE_BEATS; k++) begin
			block[k*32 +: 32] = $random(seed);
		end
		wrBefore = wrReqCnt;
		rdBefore = rdReqCnt;
		@(posedge gpuClk);
		isBlending <= 1'b1;
		exportedBgBlock <= block;
		exportedBgMask <= mask;
		saveAdr <= saveLine;
		loadAdr <= loadLine;
		bgCmd <= BG_FURTHER;
		do begin
			@(negedge gpuClk);
		end while (!memReq);
		// Busy from the save request through the import pulse
		do begin
			@(negedge gpuClk);
			expectTrue(saveLoadOnGoing, "saveLoadOnGoing_o dropped before the block was imported");
		end while (!importPulse);
		checkLoadedBlock(loadLine);
		for (int k = 0; k < `LINE_BEATS; k++) begin
			wAdr = {saveLine, CntW'(k)};
			expW = mergeHalves(initWord(wAdr), block[k*32 +: 32], mask[2*k +: 2]);
			expectTrue(busMem.mem[wAdr] === expW, $sformatf("saved word %0d is %h, expected %h",
				k, busMem.mem[wAdr], expW));
		end
		@(negedge gpuClk);
		expectTrue(!saveLoadOnGoing, "saveLoadOnGoing_o still high after the import pulse");
		@(posedge gpuClk);
		bgCmd <= BG_NONE;
		isBlending <= 1'b0;
		expectTrue(wrReqCnt == wrBefore + 1 && rdReqCnt == rdBefore + 1,
			"further block did not give exactly one write and one read request");
		finishTest("further block with blending", errBefore);
	endtask

	task automatic firstBlock();
		int                     errBefore;
		int                     wrBefore;
		int                     rdBefore;
		logic [`CLUT_ADR_W-1:0] loadLine;
		errBefore = errCnt;
		loadLine = 15'h0300;
		wrBefore = wrReqCnt;
		rdBefore = rdReqCnt;
		// Without blending the command is ignored
		@(posedge gpuClk);
		isBlending <= 1'b0;
		bgCmd <= BG_FIRST;
		repeat (20) @(posedge gpuClk);
		expectTrue(wrReqCnt == wrBefore && rdReqCnt == rdBefore,
			"first block without blending started a memory request");
		bgCmd <= BG_NONE;
		repeat (2) @(posedge gpuClk);
		isBlending <= 1'b1;
		loadAdr <= loadLine;
		bgCmd <= BG_FIRST;
		waitImport();
		checkLoadedBlock(loadLine);
		@(posedge gpuClk);
		bgCmd <= BG_NONE;
		isBlending <= 1'b0;
		repeat (2) @(posedge gpuClk);
		expectTrue(wrReqCnt == wrBefore, "first block with blending wrote to memory");
		expectTrue(rdReqCnt == rdBefore + 1, "first block with blending did not read exactly once");
		finishTest("first block", errBefore);
	endtask

	// ----------------------------------------------------------------------
	// Sequence
	// ----------------------------------------------------------------------
	initial begin
		seed = 32'hb438eb48;
		resetX = 1'b1;
		requTexL = 1'b0;
		requTexR = 1'b0;
		adrTexL = '0;
		adrTexR = '0;
		requClutL = 1'b0;
		requClutR = 1'b0;
		adrClutL = '0;
		adrClutR = '0;
		isBlending = 1'b0;
		bgCmd = BG_NONE;
		saveAdr = '0;
		loadAdr = '0;
		exportedBgBlock = '0;
		exportedBgMask = '0;
		repeat (5) @(posedge gpuClk);
		resetX <= 1'b0;
		@(posedge gpuClk);
		texLeftRefill();
		clutRightRefill();
		priorityOrder();
		furtherBlockBlend();
		firstBlock();
		repeat (4) @(posedge gpuClk);
		$display("Tests run %0d, failed %0d, errors %0d", testCnt, failCnt, errCnt);
		if (errCnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
